// File: build.f
logic/ecc_pkg.sv
logic/pin_delay.sv
logic/sipo_shift.sv
logic/ram_arbiter.sv
logic/mod_addsub_unit.sv
logic/mod_mul_unit.sv
logic/field_alu_core.sv
logic/ecc_top.sv
tb/clock_gen.sv
tb/ecc_assertions.sv
tb/ecc_top_tb.sv

// File: logic/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    ////////////////////
    // Operation select
    // Bit 2 asks for a curve operation, not supported here
    // Bits 1:0 are add, sub, mul, square
    typedef logic [2:0] mode_t;

    ////////////////////
    // Status seen on the pins
    typedef logic [1:0] status_t;

    localparam status_t STATUS_IDLE = 2'd0;
    localparam status_t STATUS_BUSY = 2'd1;
    localparam status_t STATUS_DONE = 2'd2;
    localparam status_t STATUS_ERR  = 2'd3;

    // Operand RAM words, result goes last
    typedef enum logic [1:0] {
        P_SLOT = 2'd0,
        A_SLOT = 2'd1,
        B_SLOT = 2'd2,
        R_SLOT = 2'd3
    } slot_e;

    // Sequencer states
    typedef enum logic [2:0] {IDLE, LOAD, RUN, FETCH, SHIFT, ERROR} core_state_e;

    // Requesters on the RAM, core first
    localparam int NUM_PORTS = 3;

endpackage

`default_nettype wire

// File: logic/ecc_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_top #(
    parameter int WIDTH = 16,
    parameter int ADDR  = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             din,
    input  ecc_pkg::mode_t   mode,
    input  logic             start,
    output logic             dout,
    output ecc_pkg::status_t status
);

    logic               din_d;
    ecc_pkg::mode_t     mode_d;
    logic               start_d;
    logic [3*WIDTH-1:0] frame;
    logic               core_dout;
    ecc_pkg::status_t   core_status;

    ////////////////////
    // Input pin flops
    pin_delay #(.STAGES(3), .W(1)) u_din_dly (
        .clk (clk), .rst (rst), .d (din), .q (din_d)
    );

    pin_delay #(.STAGES(3), .W(3)) u_mode_dly (
        .clk (clk), .rst (rst), .d (mode), .q (mode_d)
    );

    // Same depth as din so start lines up with the frame
    pin_delay #(.STAGES(3), .W(1)) u_start_dly (
        .clk (clk), .rst (rst), .d (start), .q (start_d)
    );

    // p on top, a in the middle, b at the bottom
    sipo_shift #(.LEN(3*WIDTH)) u_sipo_shift (
        .clk   (clk),
        .rst   (rst),
        .sdata (din_d),
        .pdata (frame)
    );

    field_alu_core #(.WIDTH(WIDTH), .ADDR(ADDR)) u_field_alu_core (
        .clk    (clk),
        .rst    (rst),
        .frame  (frame),
        .mode   (mode_d),
        .start  (start_d),
        .dout   (core_dout),
        .status (core_status)
    );

    ////////////////////
    // Output pin flops
    pin_delay #(.STAGES(3), .W(1)) u_dout_dly (
        .clk (clk), .rst (rst), .d (core_dout), .q (dout)
    );

    pin_delay #(.STAGES(3), .W(2)) u_status_dly (
        .clk (clk), .rst (rst), .d (core_status), .q (status)
    );

endmodule

`default_nettype wire

// File: logic/field_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module field_alu_core #(
    parameter int WIDTH = 16,
    parameter int ADDR  = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [3*WIDTH-1:0]     frame,
    input  ecc_pkg::mode_t         mode,
    input  logic                   start,
    output logic                   dout,
    output ecc_pkg::status_t       status
);

    ecc_pkg::core_state_e state;
    ecc_pkg::mode_t       mode_q;
    logic [3*WIDTH-1:0]   frame_q;
    // Slot being loaded
    logic [1:0]           cnt;
    logic                 pend;
    logic                 go;
    logic                 accept;
    logic [WIDTH-1:0]     sreg;

    // Arbiter side
    logic [ecc_pkg::NUM_PORTS-1:0]            arb_req;
    logic [ecc_pkg::NUM_PORTS-1:0]            arb_we;
    logic [ecc_pkg::NUM_PORTS-1:0][ADDR-1:0]  arb_addr;
    logic [ecc_pkg::NUM_PORTS-1:0][WIDTH-1:0] arb_wdata;
    logic [ecc_pkg::NUM_PORTS-1:0]            arb_gnt;
    logic [WIDTH-1:0]                         arb_rdata;

    logic             core_req;
    logic [WIDTH-1:0] core_wdata;
    logic             as_done;
    logic             as_req;
    logic             as_we;
    logic [ADDR-1:0]  as_addr;
    logic [WIDTH-1:0] as_wdata;
    logic             mul_done;
    logic             mul_req;
    logic             mul_we;
    logic [ADDR-1:0]  mul_addr;
    logic [WIDTH-1:0] mul_wdata;

    ////////////////////
    // Port 0, the sequencer
    assign core_req = (state == ecc_pkg::LOAD) || ((state == ecc_pkg::FETCH) && !pend);

    always_comb begin
        case (cnt)
            ecc_pkg::P_SLOT: core_wdata = frame_q[3*WIDTH-1 -: WIDTH];
            ecc_pkg::A_SLOT: core_wdata = frame_q[2*WIDTH-1 -: WIDTH];
            default:         core_wdata = frame_q[WIDTH-1:0];
        endcase
    end

    assign arb_req      = {mul_req, as_req, core_req};
    assign arb_we       = {mul_we, as_we, (state == ecc_pkg::LOAD)};
    assign arb_addr[0]  = (state == ecc_pkg::FETCH) ? ADDR'(ecc_pkg::R_SLOT) : ADDR'(cnt);
    assign arb_addr[1]  = as_addr;
    assign arb_addr[2]  = mul_addr;
    assign arb_wdata[0] = core_wdata;
    assign arb_wdata[1] = as_wdata;
    assign arb_wdata[2] = mul_wdata;

    ram_arbiter #(.WIDTH(WIDTH), .ADDR(ADDR)) u_ram_arbiter (
        .clk   (clk),
        .rst   (rst),
        .req   (arb_req),
        .we    (arb_we),
        .addr  (arb_addr),
        .wdata (arb_wdata),
        .gnt   (arb_gnt),
        .rdata (arb_rdata)
    );

    // Mode bit 0 picks sub over add, square over mul
    mod_addsub_unit #(.WIDTH(WIDTH), .ADDR(ADDR)) u_mod_addsub_unit (
        .clk   (clk),
        .rst   (rst),
        .go    (go && !mode_q[1]),
        .sub   (mode_q[0]),
        .done  (as_done),
        .req   (as_req),
        .we    (as_we),
        .addr  (as_addr),
        .wdata (as_wdata),
        .gnt   (arb_gnt[1]),
        .rdata (arb_rdata)
    );

    mod_mul_unit #(.WIDTH(WIDTH), .ADDR(ADDR)) u_mod_mul_unit (
        .clk    (clk),
        .rst    (rst),
        .go     (go && mode_q[1]),
        .square (mode_q[0]),
        .done   (mul_done),
        .req    (mul_req),
        .we     (mul_we),
        .addr   (mul_addr),
        .wdata  (mul_wdata),
        .gnt    (arb_gnt[2]),
        .rdata  (arb_rdata)
    );

    ////////////////////
    // Sequencer
    // Start only taken when no operation is in flight
    assign accept = start && ((state == ecc_pkg::IDLE) || (state == ecc_pkg::SHIFT) ||
                              (state == ecc_pkg::ERROR));

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q <= frame;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ecc_pkg::IDLE;
            mode_q <= '0;
            cnt    <= '0;
            pend   <= 1'b0;
            go     <= 1'b0;
            sreg   <= '0;
        end else begin
            go <= 1'b0;
            if (accept) begin
                mode_q <= mode;
                cnt    <= '0;
                // Error leaves dout low
                sreg   <= '0;
                state  <= mode[2] ? ecc_pkg::ERROR : ecc_pkg::LOAD;
            end else begin
                case (state)
                    ecc_pkg::LOAD: begin
                        if (arb_gnt[0]) begin
                            if (cnt == 2'd2) begin
                                go    <= 1'b1;
                                state <= ecc_pkg::RUN;
                            end else begin
                                cnt <= cnt + 2'd1;
                            end
                        end
                    end
                    ecc_pkg::RUN: begin
                        if (as_done || mul_done) begin
                            state <= ecc_pkg::FETCH;
                        end
                    end
                    ecc_pkg::FETCH: begin
                        // Result read back, bit 0 out with done
                        if (pend) begin
                            pend  <= 1'b0;
                            sreg  <= arb_rdata;
                            state <= ecc_pkg::SHIFT;
                        end else if (arb_gnt[0]) begin
                            pend <= 1'b1;
                        end
                    end
                    ecc_pkg::SHIFT: sreg <= {1'b0, sreg[WIDTH-1:1]};
                    default: ;
                endcase
            end
        end
    end

    assign dout = sreg[0];

    // Status follows the state
    always_comb begin
        case (state)
            ecc_pkg::IDLE:  status = ecc_pkg::STATUS_IDLE;
            ecc_pkg::SHIFT: status = ecc_pkg::STATUS_DONE;
            ecc_pkg::ERROR: status = ecc_pkg::STATUS_ERR;
            default:        status = ecc_pkg::STATUS_BUSY;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mod_addsub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mod_addsub_unit #(
    parameter int WIDTH = 16,
    parameter int ADDR  = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  logic             sub,
    output logic             done,
    output logic             req,
    output logic             we,
    output logic [ADDR-1:0]  addr,
    output logic [WIDTH-1:0] wdata,
    input  logic             gnt,
    input  logic [WIDTH-1:0] rdata
);

    typedef enum logic [1:0] {AS_IDLE, AS_READ, AS_WRITE} as_state_e;

    as_state_e        state;
    // Slot being read, p then a then b
    logic [1:0]       idx;
    // Read granted, data due this cycle
    logic             pend;
    logic [WIDTH-1:0] p_q;
    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;
    logic [WIDTH:0]   sum;
    logic [WIDTH:0]   fix;

    ////////////////////
    // Datapath
    // Top bit of sum holds the carry or the borrow
    always_comb begin
        if (sub) begin
            sum   = {1'b0, a_q} - {1'b0, b_q};
            fix   = sum + {1'b0, p_q};
            wdata = sum[WIDTH] ? fix[WIDTH-1:0] : sum[WIDTH-1:0];
        end else begin
            sum   = {1'b0, a_q} + {1'b0, b_q};
            fix   = sum - {1'b0, p_q};
            // Borrow on fix means sum was already below p
            wdata = fix[WIDTH] ? sum[WIDTH-1:0] : fix[WIDTH-1:0];
        end
    end

    // RAM side
    assign req  = ((state == AS_READ) && !pend) || (state == AS_WRITE);
    assign we   = (state == AS_WRITE);
    assign addr = (state == AS_WRITE) ? ADDR'(ecc_pkg::R_SLOT) : ADDR'(idx);

    // Operand capture
    always_ff @(posedge clk) begin
        if (pend) begin
            case (idx)
                2'd0:    p_q <= rdata;
                2'd1:    a_q <= rdata;
                default: b_q <= rdata;
            endcase
        end
    end

    ////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= AS_IDLE;
            idx   <= '0;
            pend  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                AS_IDLE: begin
                    if (go) begin
                        state <= AS_READ;
                        idx   <= '0;
                    end
                end
                AS_READ: begin
                    if (pend) begin
                        pend <= 1'b0;
                        if (idx == 2'd2) begin
                            state <= AS_WRITE;
                        end else begin
                            idx <= idx + 2'd1;
                        end
                    end else if (gnt) begin
                        pend <= 1'b1;
                    end
                end
                default: begin
                    // Result written at this edge
                    if (gnt) begin
                        done  <= 1'b1;
                        state <= AS_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/mod_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mod_mul_unit #(
    parameter int WIDTH = 16,
    parameter int ADDR  = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  logic             square,
    output logic             done,
    output logic             req,
    output logic             we,
    output logic [ADDR-1:0]  addr,
    output logic [WIDTH-1:0] wdata,
    input  logic             gnt,
    input  logic [WIDTH-1:0] rdata
);

    localparam int CW = $clog2(WIDTH + 1);

    typedef enum logic [1:0] {MU_IDLE, MU_READ, MU_LOOP, MU_WRITE} mu_state_e;

    mu_state_e        state;
    logic [1:0]       idx;
    logic             pend;
    logic             last_rd;
    logic [CW-1:0]    cnt;
    logic [WIDTH-1:0] p_q;
    // Multiplicand
    logic [WIDTH-1:0] a_q;
    // Multiplier, scanned from the top
    logic [WIDTH-1:0] m_q;
    logic [WIDTH-1:0] acc_q;
    logic [WIDTH:0]   dbl;
    logic [WIDTH:0]   dbl_r;
    logic [WIDTH:0]   add;
    logic [WIDTH:0]   add_r;

    ////////////////////
    // One interleaved step
    // Both partial values stay below 2p
    always_comb begin
        dbl   = {acc_q, 1'b0};
        dbl_r = (dbl >= {1'b0, p_q}) ? dbl - {1'b0, p_q} : dbl;
        add   = m_q[WIDTH-1] ? dbl_r + {1'b0, a_q} : dbl_r;
        add_r = (add >= {1'b0, p_q}) ? add - {1'b0, p_q} : add;
    end

    // Square stops after a
    assign last_rd = (idx == (square ? 2'd1 : 2'd2));

    assign req   = ((state == MU_READ) && !pend) || (state == MU_WRITE);
    assign we    = (state == MU_WRITE);
    assign addr  = (state == MU_WRITE) ? ADDR'(ecc_pkg::R_SLOT) : ADDR'(idx);
    assign wdata = acc_q;

    // Operands and accumulator
    always_ff @(posedge clk) begin
        if (pend) begin
            case (idx)
                2'd0: p_q <= rdata;
                2'd1: begin
                    a_q <= rdata;
                    if (square) begin
                        m_q <= rdata;
                    end
                end
                default: m_q <= rdata;
            endcase
            if (last_rd) begin
                acc_q <= '0;
            end
        end else if (state == MU_LOOP) begin
            acc_q <= add_r[WIDTH-1:0];
            m_q   <= {m_q[WIDTH-2:0], 1'b0};
        end
    end

    ////////////////////
    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MU_IDLE;
            idx   <= '0;
            pend  <= 1'b0;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MU_IDLE: begin
                    if (go) begin
                        state <= MU_READ;
                        idx   <= '0;
                    end
                end
                MU_READ: begin
                    if (pend) begin
                        pend <= 1'b0;
                        idx  <= idx + 2'd1;
                        if (last_rd) begin
                            state <= MU_LOOP;
                            cnt   <= CW'(WIDTH);
                        end
                    end else if (gnt) begin
                        pend <= 1'b1;
                    end
                end
                MU_LOOP: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == CW'(1)) begin
                        state <= MU_WRITE;
                    end
                end
                default: begin
                    if (gnt) begin
                        done  <= 1'b1;
                        state <= MU_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/pin_delay.sv
`timescale 1ns/1ps
`default_nettype none

module pin_delay #(
    parameter int STAGES = 3,
    parameter int W      = 1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [W-1:0] d,
    output logic [W-1:0] q
);

    // Stage 0 sits next to the pin
    logic [W-1:0] pipe [STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= d;
            for (int i = 1; i < STAGES; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign q = pipe[STAGES-1];

endmodule

`default_nettype wire

// File: logic/ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter #(
    parameter int WIDTH = 16,
    parameter int ADDR  = 5
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [ecc_pkg::NUM_PORTS-1:0]               req,
    input  logic [ecc_pkg::NUM_PORTS-1:0]               we,
    input  logic [ecc_pkg::NUM_PORTS-1:0][ADDR-1:0]     addr,
    input  logic [ecc_pkg::NUM_PORTS-1:0][WIDTH-1:0]    wdata,
    output logic [ecc_pkg::NUM_PORTS-1:0]               gnt,
    output logic [WIDTH-1:0]                            rdata
);

    // Single port operand store
    logic [WIDTH-1:0] mem [1<<ADDR];

    logic             hit;
    logic             sel_we;
    logic [ADDR-1:0]  sel_addr;
    logic [WIDTH-1:0] sel_wdata;

    ////////////////////
    // Fixed priority pick
    // Scan from the top so the lowest index wins
    always_comb begin
        gnt       = '0;
        hit       = 1'b0;
        sel_we    = 1'b0;
        sel_addr  = '0;
        sel_wdata = '0;
        for (int i = ecc_pkg::NUM_PORTS - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt       = '0;
                gnt[i]    = 1'b1;
                hit       = 1'b1;
                sel_we    = we[i];
                sel_addr  = addr[i];
                sel_wdata = wdata[i];
            end
        end
    end

    ////////////////////
    // Access at the grant edge
    always_ff @(posedge clk) begin
        if (hit && sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // Read data lands one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (hit && !sel_we) begin
            rdata <= mem[sel_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/sipo_shift.sv
`timescale 1ns/1ps
`default_nettype none

module sipo_shift #(
    parameter int LEN = 48
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           sdata,
    output logic [LEN-1:0] pdata
);

    // Free running, new bit enters at the bottom
    // First bit of a frame ends up on top
    always_ff @(posedge clk) begin
        if (rst) begin
            pdata <= '0;
        end else begin
            pdata <= {pdata[LEN-2:0], sdata};
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the ecc_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ecc_top_tb -f build.f -o ecc_sim --Mdir obj_dir > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/ecc_sim > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Some tests failed" "$SIM_LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

// File: tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    // Free running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/ecc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic [ecc_pkg::NUM_PORTS-1:0] req,
    input logic [ecc_pkg::NUM_PORTS-1:0] gnt,
    input ecc_pkg::status_t              status,
    input ecc_pkg::mode_t                mode,
    input logic                          start
);

    ////////////////////
    // Arbiter
    gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else $error("arbiter grant is not one-hot");

    // No grant without a request behind it
    gnt_needs_req: assert property (@(posedge clk) disable iff (rst) (gnt & ~req) == '0)
        else $error("arbiter granted a port that did not request");

    // Lowest active index wins
    gnt_lowest: assert property (@(posedge clk) disable iff (rst) gnt == (req & -req))
        else $error("arbiter grant skipped a higher priority port");

    ////////////////////
    // Core status
    // Mode on the core input is held from start until the next start
    err_needs_mode: assert property (@(posedge clk) disable iff (rst)
        (status == ecc_pkg::STATUS_ERR && !start) |-> mode[2])
        else $error("core reports error for a supported mode");

endmodule

// Arbiter ports are seen through the core's wires
bind field_alu_core ecc_assertions u_ecc_assertions (
    .clk    (clk),
    .rst    (rst),
    .req    (arb_req),
    .gnt    (arb_gnt),
    .status (status),
    .mode   (mode),
    .start  (start)
);

`default_nettype wire

// File: tb/ecc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_top_tb;

    localparam int WIDTH           = 16;
    localparam int ADDR            = 5;
    localparam int FRAME           = 3 * WIDTH;
    localparam int MAX_TESTS       = 64;
    localparam int NAME_W          = 8 * 24;
    localparam int LINE_W          = 8 * 160;
    localparam int CYCLES_PER_TEST = 3 * WIDTH + 2 * WIDTH + 60;

    logic             clk;
    logic             rst;
    logic             din;
    logic             start;
    logic             dout;
    ecc_pkg::mode_t   mode;
    ecc_pkg::status_t status;

    // Trace contents, one entry per vector line
    logic [NAME_W-1:0] t_name   [MAX_TESTS];
    logic [2:0]        t_mode   [MAX_TESTS];
    logic [WIDTH-1:0]  t_p      [MAX_TESTS];
    logic [WIDTH-1:0]  t_a      [MAX_TESTS];
    logic [WIDTH-1:0]  t_b      [MAX_TESTS];
    logic [WIDTH-1:0]  t_exp    [MAX_TESTS];
    logic [1:0]        t_status [MAX_TESTS];

    int num_tests;
    int pass_count;
    int fail_count;
    int cycle_count;
    int cycle_limit;

    clock_gen #(.PERIOD(8), .RESET_CYCLES(8)) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ecc_top #(.WIDTH(WIDTH), .ADDR(ADDR)) u_ecc_top (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .mode   (mode),
        .start  (start),
        .dout   (dout),
        .status (status)
    );

    ////////////////////
    // Trace reader
    // Lines that do not give all seven columns are skipped
    task automatic load_trace();
        int                fd;
        int                n;
        logic [LINE_W-1:0] line;
        logic [NAME_W-1:0] name;
        logic [31:0]       m;
        logic [31:0]       p;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       e;
        logic [31:0]       s;
        num_tests = 0;
        fd = $fopen("tb/ecc_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/ecc_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", name, m, p, a, b, e, s);
                if (n == 7 && num_tests < MAX_TESTS) begin
                    t_name[num_tests]   = name;
                    t_mode[num_tests]   = m[2:0];
                    t_p[num_tests]      = p[WIDTH-1:0];
                    t_a[num_tests]      = a[WIDTH-1:0];
                    t_b[num_tests]      = b[WIDTH-1:0];
                    t_exp[num_tests]    = e[WIDTH-1:0];
                    t_status[num_tests] = s[1:0];
                    num_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Frame goes out MSB first, start follows the last bit
    task automatic send_frame(input logic [WIDTH-1:0] p, input logic [WIDTH-1:0] a,
                              input logic [WIDTH-1:0] b, input logic [2:0] m);
        logic [FRAME-1:0] frame;
        frame = {p, a, b};
        for (int i = FRAME - 1; i >= 0; i--) begin
            @(negedge clk);
            din = frame[i];
        end
        @(negedge clk);
        din   = 1'b0;
        start = 1'b1;
        // Mode stays put until the next start
        mode  = m;
        @(negedge clk);
        start = 1'b0;
    endtask

    ////////////////////
    // One vector, start to last result bit
    task automatic run_test(input int idx);
        ecc_pkg::status_t prev;
        logic [WIDTH-1:0] got;
        logic             ok;
        logic             saw_busy;
        ok   = 1'b1;
        prev = status;
        send_frame(t_p[idx], t_a[idx], t_b[idx], t_mode[idx]);
        // Old status lingers until the new start gets through the pin flops
        while (status == prev ||
               (status != ecc_pkg::STATUS_BUSY && status != ecc_pkg::STATUS_ERR)) begin
            @(negedge clk);
        end
        saw_busy = (status == ecc_pkg::STATUS_BUSY);
        if (!t_mode[idx][2] && !saw_busy) begin
            $display("Test %0s: status did not go busy after start", t_name[idx]);
            ok = 1'b0;
        end
        if (saw_busy) begin
            while (status != ecc_pkg::STATUS_DONE && status != ecc_pkg::STATUS_ERR) begin
                @(negedge clk);
            end
        end
        if (status != t_status[idx]) begin
            $display("CHECK FAILED test %0s status: expected %0d, actual %0d",
                     t_name[idx], t_status[idx], status);
            ok = 1'b0;
        end
        // Bit 0 shows with the new status, the rest follow one per cycle
        got = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            got[i] = dout;
        end
        if (got != t_exp[idx]) begin
            $display("CHECK FAILED test %0s result: expected %h, actual %h",
                     t_name[idx], t_exp[idx], got);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("Test %0s: %s", t_name[idx], ok ? "ok" : "failed");
    endtask

    ////////////////////
    // Main sequence
    initial begin : main_flow
        int gap;
        din         = 1'b0;
        start       = 1'b0;
        mode        = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_limit = 0;
        void'($urandom(32'hde0790f8));
        load_trace();
        if (num_tests == 0) begin
            $display("No test vectors were read from the trace file");
            fail_count++;
        end
        cycle_limit = num_tests * CYCLES_PER_TEST;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        if (status != ecc_pkg::STATUS_IDLE || dout != 1'b0) begin
            $display("Status is not idle or dout is not low after reset");
            fail_count++;
        end
        for (int i = 0; i < num_tests; i++) begin
            // Every odd vector starts right after the previous result
            if (i % 2 == 1) begin
                gap = 0;
            end else begin
                gap = int'($urandom % 8);
            end
            repeat (gap) @(negedge clk);
            run_test(i);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", num_tests, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Run length bound, set once the trace is known
    initial begin : watchdog
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/ecc_trace.txt
# columns: name mode p a b expected_result expected_status
# hex fields, status 2 is done and 3 is error
add_small 0 fff1 1234 0f0f 2143 2
add_wrap 0 fff1 fff0 0005 0004 2
sub_ge 1 fff1 5000 1234 3dcc 2
sub_lt 1 fff1 0010 0020 ffe1 2
mul_full 2 fff1 fff0 ffef 0002 2
mul_small 2 0065 0032 0021 0022 2
mul_wrap 2 fff1 8000 0002 000f 2
sqr_plain 3 fff1 0100 0000 000f 2
sqr_junk_b 3 fff1 0100 ffff 000f 2
err_curve 4 fff1 0001 0002 0000 3
add_after_err 0 0065 0064 0064 0063 2
err_curve_hi 7 0065 0003 0004 0000 3
mul_after_err 2 0065 0064 0064 0001 2
